// ==== tb.f ====
+incdir+hw
hw/lsu_pkg.sv
hw/dtlb.sv
hw/mem1_stage.sv
hw/dmem.sv
hw/mem2_stage.sv
hw/lsu_top.sv
dv/tb_lsu.sv

// ==== Bender.yml ====
package:
  name: lsu

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/lsu_pkg.sv
      - hw/dtlb.sv
      - hw/mem1_stage.sv
      - hw/dmem.sv
      - hw/mem2_stage.sv
      - hw/lsu_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - dv/tb_lsu.sv

// ==== dv/tb_lsu.sv ====
`timescale 1ns/10ps
`include "lsu_settings.svh"

module tb_lsu
    import lsu_pkg::*;
();

    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DELAY  = 5;
    localparam int RESET_CYCLES = 16;
    localparam int FILL_WORDS   = 16;
    localparam int RAND_OPS     = 48;
    // Fill and readback, random mix, translation, exceptions, LL/SC, flush
    localparam int NUM_OPS      = 2 * FILL_WORDS + RAND_OPS + 3 + 14 + 5 + 2;
    localparam int CYCLE_LIMIT  = 8 * NUM_OPS + RESET_CYCLES;
    // Physical words that the faulting stores would hit
    localparam logic [31:0] VICTIM [4] = '{32'h0000_20C0, 32'h0000_30D0,
                                           32'h0000_30E0, 32'h0000_00F0};

    logic       clk;
    logic       rst;
    logic       flush;
    ex_mem_t    ex;
    plv_t       csr_plv;
    logic       tlb_we;
    logic [1:0] tlb_widx;
    tlb_entry_t tlb_entry;
    logic       ex_ready;
    wb_t        wb;

    logic [7:0] model_mem [1024];
    logic       ll_model;
    logic [31:0] rng;
    int         test_id;
    int         cycles = 0;
    wb_t        exp_q [$];
    int         id_q [$];
    wb_t        exp_head;
    int         exp_id;
    logic       accept_d1;
    logic       due;
    logic       killed;

    lsu_top lsu_top_inst (
        .clk         (clk),
        .rst         (rst),
        .flush_i     (flush),
        .ex_i        (ex),
        .csr_plv_i   (csr_plv),
        .tlb_we_i    (tlb_we),
        .tlb_widx_i  (tlb_widx),
        .tlb_entry_i (tlb_entry),
        .ex_ready_o  (ex_ready),
        .wb_o        (wb)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic excp_vec_t excp_only(input int pos);
        return excp_vec_t'(1) << pos;
    endfunction

    function automatic tlb_entry_t make_entry(input vppn_t vppn, input ppn_t ppn,
                                              input logic v, input logic d, input plv_t plv);
        tlb_entry_t e;
        e.vppn = vppn;
        e.ppn  = ppn;
        e.v    = v;
        e.d    = d;
        e.plv  = plv;
        return e;
    endfunction

    function automatic string test_label(input int id);
        case (id)
            1:       return "random_untranslated";
            2:       return "translation";
            3:       return "exceptions";
            4:       return "ll_sc";
            5:       return "flush";
            default: return "unknown";
        endcase
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic report_mismatch(input string name, input wb_t exp, input wb_t act);
        stop_with_failure($sformatf("ERR %s: expected %h actual %h", name, exp, act));
    endtask

    // Little-endian byte memory, indexed by paddr[9:0]
    function automatic word_t read_model(input mem_op_e op, input word_t pa);
        logic [7:0] b0;
        logic [7:0] b1;
        logic [9:0] a;
        word_t      w;
        a  = pa[9:0];
        b0 = model_mem[a];
        b1 = model_mem[a + 10'd1];
        w  = {model_mem[{a[9:2], 2'd3}], model_mem[{a[9:2], 2'd2}],
              model_mem[{a[9:2], 2'd1}], model_mem[{a[9:2], 2'd0}]};
        case (op)
            LD_B:    return {{24{b0[7]}}, b0};
            LD_BU:   return {24'h0, b0};
            LD_H:    return {{16{b1[7]}}, b1, b0};
            LD_HU:   return {16'h0, b1, b0};
            default: return w;
        endcase
    endfunction

    task automatic write_model(input mem_op_e op, input word_t pa, input word_t sd);
        logic [9:0] a;
        a = pa[9:0];
        case (op)
            ST_B: model_mem[a] = sd[7:0];
            ST_H: begin
                model_mem[a]         = sd[7:0];
                model_mem[a + 10'd1] = sd[15:8];
            end
            default: begin
                for (int b = 0; b < 4; b++) begin
                    model_mem[{a[9:2], 2'(b)}] = sd[8*b +: 8];
                end
            end
        endcase
    endtask

    task automatic write_tlb_entry(input logic [1:0] idx, input tlb_entry_t e);
        tlb_widx  = idx;
        tlb_entry = e;
        tlb_we    = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        tlb_we = 1'b0;
    endtask

    // Present one record, queue its expected writeback, return after acceptance
    task automatic issue_record(input mem_op_e op, input word_t vaddr, input word_t paddr,
                                input word_t sdata, input logic trans,
                                input excp_vec_t exp_excp);
        ex_mem_t rec;
        wb_t     exp;
        logic    is_load;
        logic    is_store;
        logic    accepted;
        rng      = xorshift32(rng);
        is_load  = op inside {LD_B, LD_BU, LD_H, LD_HU, LD_W, LL};
        is_store = op inside {ST_B, ST_H, ST_W, SC};
        rec          = '0;
        rec.valid    = 1'b1;
        rec.op       = op;
        rec.vaddr    = vaddr;
        rec.sdata    = sdata;
        rec.wreg     = !is_store;
        rec.waddr    = rng[4:0];
        rec.wdata    = (op == NONE) ? rng : '0;
        rec.trans_en = trans;
        exp.valid = 1'b1;
        exp.waddr = rec.waddr;
        exp.excp  = exp_excp;
        exp.wreg  = rec.wreg;
        exp.wdata = rec.wdata;
        if (exp_excp != '0) begin
            exp.wreg = 1'b0;
        end else if (op == SC) begin
            exp.wreg  = 1'b1;
            exp.wdata = word_t'(ll_model);
            if (ll_model) begin
                write_model(ST_W, paddr, sdata);
            end
            ll_model = 1'b0;
        end else if (is_load) begin
            exp.wdata = read_model(op, paddr);
            if (op == LL) begin
                ll_model = 1'b1;
            end
        end else if (is_store) begin
            write_model(op, paddr, sdata);
        end
        exp_q.push_back(exp);
        id_q.push_back(test_id);
        ex = rec;
        do begin
            @(negedge clk);
            accepted = ex_ready;
            @(posedge clk);
        end while (!accepted);
        #DRIVE_DELAY;
        ex = '0;
    endtask

    // Expected writeback falls due two edges after acceptance
    always @(posedge clk) begin
        if (rst) begin
            accept_d1 <= 1'b0;
            due       <= 1'b0;
            killed    <= 1'b0;
        end else begin
            accept_d1 <= ex.valid && ex_ready;
            due       <= accept_d1;
            killed    <= accept_d1 && flush;
            if (accept_d1 && exp_q.size() > 0) begin
                exp_head <= exp_q.pop_front();
                exp_id   <= id_q.pop_front();
            end
        end
    end

    always @(posedge clk) begin
        if (cycles >= CYCLE_LIMIT) begin
            stop_with_failure($sformatf("Timeout: run still going after %0d cycles", cycles));
        end else begin
            cycles <= cycles + 1;
        end
    end

    a_wb_match: assert property (@(posedge clk) disable iff (rst)
        (due && !killed) |-> (wb === exp_head))
        else report_mismatch(test_label($sampled(exp_id)), $sampled(exp_head), $sampled(wb));

    a_no_stray_wb: assert property (@(posedge clk) disable iff (rst)
        !(due && !killed) |-> !wb.valid)
        else stop_with_failure("A writeback appeared where none was due");

    a_reset_state: assert property (@(posedge clk)
        $fell(rst) |-> (!wb.valid && ex_ready))
        else stop_with_failure("After reset the writeback was valid or ex_ready was low");

    a_idle_ready: assert property (@(posedge clk) disable iff (rst)
        !ex.valid |-> ex_ready)
        else stop_with_failure("ex_ready was low with no record presented");

    initial begin
        mem_op_e    op;
        word_t      addr;
        logic [1:0] lane;
        rst       = 1'b1;
        flush     = 1'b0;
        ex        = '0;
        csr_plv   = '0;
        tlb_we    = 1'b0;
        tlb_widx  = '0;
        tlb_entry = '0;
        rng       = 32'hafe2_c033;
        ll_model  = 1'b0;
        test_id   = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        @(posedge clk);
        #DRIVE_DELAY;

        test_id = 1;
        for (int i = 0; i < FILL_WORDS; i++) begin
            rng = xorshift32(rng);
            issue_record(ST_W, word_t'(4 * i), word_t'(4 * i), rng, 1'b0, '0);
        end
        for (int i = 0; i < RAND_OPS; i++) begin
            rng = xorshift32(rng);
            op  = mem_op_e'(4'(rng % 32'd9));
            case (op)
                LD_B, LD_BU, ST_B: lane = rng[13:12];
                LD_H, LD_HU, ST_H: lane = {rng[13], 1'b0};
                default:           lane = 2'b00;
            endcase
            addr = {26'h0, rng[11:8], lane};
            rng  = xorshift32(rng);
            issue_record(op, addr, addr, rng, 1'b0, '0);
        end
        for (int i = 0; i < FILL_WORDS; i++) begin
            issue_record(LD_W, word_t'(4 * i), word_t'(4 * i), '0, 1'b0, '0);
        end

        test_id = 2;
        write_tlb_entry(2'd0, make_entry(20'h00040, 20'h00001, 1'b1, 1'b1, 2'd3));
        rng = xorshift32(rng);
        issue_record(ST_W, 32'h0004_0080, 32'h0000_1080, rng, 1'b1, '0);
        issue_record(LD_W, 32'h0000_1080, 32'h0000_1080, '0, 1'b0, '0);
        issue_record(LD_BU, 32'h0004_0083, 32'h0000_1083, '0, 1'b1, '0);

        test_id = 3;
        write_tlb_entry(2'd1, make_entry(20'h00050, 20'h00002, 1'b0, 1'b1, 2'd3));
        write_tlb_entry(2'd2, make_entry(20'h00060, 20'h00003, 1'b1, 1'b1, 2'd0));
        write_tlb_entry(2'd3, make_entry(20'h00070, 20'h00003, 1'b1, 1'b0, 2'd3));
        for (int i = 0; i < 4; i++) begin
            rng = xorshift32(rng);
            issue_record(ST_W, VICTIM[i], VICTIM[i], rng, 1'b0, '0);
        end
        issue_record(LD_W, 32'h0007_7000, 32'h0, '0, 1'b1, excp_only(`LSU_EXCP_TLBR));
        issue_record(LD_W, 32'h0005_00C0, VICTIM[0], '0, 1'b1, excp_only(`LSU_EXCP_PIL));
        issue_record(ST_W, 32'h0005_00C0, VICTIM[0], 32'h1111_2222, 1'b1,
                     excp_only(`LSU_EXCP_PIS));
        csr_plv = 2'd1;
        issue_record(ST_W, 32'h0006_00D0, VICTIM[1], 32'h3333_4444, 1'b1,
                     excp_only(`LSU_EXCP_PPI));
        csr_plv = 2'd0;
        issue_record(ST_H, 32'h0007_00E0, VICTIM[2], 32'h5555_6666, 1'b1,
                     excp_only(`LSU_EXCP_PME));
        csr_plv = 2'd3;
        issue_record(ST_W, 32'h8006_00F0, VICTIM[3], 32'h7777_8888, 1'b1,
                     excp_only(`LSU_EXCP_ADEM));
        csr_plv = 2'd0;
        for (int i = 0; i < 4; i++) begin
            issue_record(LD_W, VICTIM[i], VICTIM[i], '0, 1'b0, '0);
        end

        test_id = 4;
        rng = xorshift32(rng);
        issue_record(ST_W, 32'h0000_0200, 32'h0000_0200, rng, 1'b0, '0);
        issue_record(LL, 32'h0000_0200, 32'h0000_0200, '0, 1'b0, '0);
        rng = xorshift32(rng);
        issue_record(SC, 32'h0000_0200, 32'h0000_0200, rng, 1'b0, '0);
        rng = xorshift32(rng);
        issue_record(SC, 32'h0000_0200, 32'h0000_0200, rng, 1'b0, '0);
        issue_record(LD_W, 32'h0000_0200, 32'h0000_0200, '0, 1'b0, '0);

        // Store is acked before the flush, so memory keeps it
        test_id = 5;
        rng = xorshift32(rng);
        issue_record(ST_W, 32'h0000_0300, 32'h0000_0300, rng, 1'b0, '0);
        flush = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        flush = 1'b0;
        issue_record(LD_W, 32'h0000_0300, 32'h0000_0300, '0, 1'b0, '0);

        repeat (4) @(posedge clk);
        if (exp_q.size() != 0) begin
            stop_with_failure("Some issued records never produced a writeback");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

// ==== hw/lsu_top.sv ====
`timescale 1ns/10ps

module lsu_top
    import lsu_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       flush_i,
    input  ex_mem_t    ex_i,
    input  plv_t       csr_plv_i,
    input  logic       tlb_we_i,
    input  logic [1:0] tlb_widx_i,
    input  tlb_entry_t tlb_entry_i,
    output logic       ex_ready_o,
    output wb_t        wb_o
);

    tlb_result_t tlb_result;
    dmem_req_t   dmem_req;
    logic        dmem_ready;
    logic        dmem_ack;
    word_t       dmem_rdata;
    mem1_mem2_t  mem2_rec;

    dtlb dtlb_inst (
        .clk      (clk),
        .rst      (rst),
        .vaddr_i  (ex_i.vaddr),
        .we_i     (tlb_we_i),
        .widx_i   (tlb_widx_i),
        .entry_i  (tlb_entry_i),
        .result_o (tlb_result)
    );

    mem1_stage mem1_stage_inst (
        .clk          (clk),
        .rst          (rst),
        .flush_i      (flush_i),
        .ex_i         (ex_i),
        .tlb_result_i (tlb_result),
        .csr_plv_i    (csr_plv_i),
        .dmem_req_o   (dmem_req),
        .dmem_ready_i (dmem_ready),
        .dmem_ack_i   (dmem_ack),
        .ex_ready_o   (ex_ready_o),
        .mem2_o       (mem2_rec)
    );

    dmem dmem_inst (
        .clk     (clk),
        .rst     (rst),
        .req_i   (dmem_req),
        .ready_o (dmem_ready),
        .ack_o   (dmem_ack),
        .rdata_o (dmem_rdata)
    );

    mem2_stage mem2_stage_inst (
        .clk     (clk),
        .rst     (rst),
        .flush_i (flush_i),
        .mem2_i  (mem2_rec),
        .rdata_i (dmem_rdata),
        .wb_o    (wb_o)
    );

endmodule

// ==== hw/mem2_stage.sv ====
`timescale 1ns/10ps

module mem2_stage
    import lsu_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       flush_i,
    input  mem1_mem2_t mem2_i,
    input  word_t      rdata_i,
    output wb_t        wb_o
);

    logic  is_load;
    word_t lane;
    word_t load_data;
    wb_t   wb_d;

    assign is_load = mem2_i.op inside {LD_B, LD_BU, LD_H, LD_HU, LD_W, LL};

    // Bring the addressed byte or half-word down to bit 0
    assign lane = rdata_i >> {mem2_i.paddr_lo, 3'b000};

    always_comb begin
        case (mem2_i.op)
            LD_B:    load_data = {{24{lane[7]}}, lane[7:0]};
            LD_BU:   load_data = {24'b0, lane[7:0]};
            LD_H:    load_data = {{16{lane[15]}}, lane[15:0]};
            LD_HU:   load_data = {16'b0, lane[15:0]};
            default: load_data = rdata_i;
        endcase
    end

    always_comb begin
        wb_d.valid = mem2_i.valid;
        wb_d.waddr = mem2_i.waddr;
        wb_d.excp  = mem2_i.excp;
        // Faulting records never reach the register file
        wb_d.wreg  = mem2_i.wreg && (mem2_i.excp == '0);
        if (mem2_i.mem_access_valid && is_load) begin
            wb_d.wdata = load_data;
        end else begin
            wb_d.wdata = mem2_i.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            wb_o <= '0;
        end else begin
            wb_o <= wb_d;
        end
    end

endmodule

// ==== hw/dmem.sv ====
`timescale 1ns/10ps
`include "lsu_settings.svh"

module dmem
    import lsu_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  dmem_req_t req_i,
    output logic      ready_o,
    output logic      ack_o,
    output word_t     rdata_o
);

    localparam int IDX_W = $clog2(`LSU_DMEM_WORDS);

    word_t            mem [`LSU_DMEM_WORDS];
    logic             take;
    logic [IDX_W-1:0] idx;

    assign take = req_i.ce && ready_o;
    assign idx  = req_i.addr[IDX_W+1:2];

    // Busy for exactly the ack cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            ready_o <= 1'b1;
            ack_o   <= 1'b0;
        end else begin
            ready_o <= !take;
            ack_o   <= take;
        end
    end

    // Read word stays put until the next request
    always_ff @(posedge clk) begin
        if (take) begin
            rdata_o <= mem[idx];
            if (req_i.we) begin
                for (int b = 0; b < 4; b++) begin
                    if (req_i.sel[b]) begin
                        mem[idx][8*b +: 8] <= req_i.data[8*b +: 8];
                    end
                end
            end
        end
    end

    // Requests only arrive while ready
    a_req_while_ready: assert property (
        @(posedge clk) disable iff (rst) req_i.ce |-> ready_o
    ) else $error("dmem: request issued while busy");

endmodule

// ==== hw/mem1_stage.sv ====
`timescale 1ns/10ps
`include "lsu_settings.svh"

module mem1_stage
    import lsu_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        flush_i,
    input  ex_mem_t     ex_i,
    input  tlb_result_t tlb_result_i,
    input  plv_t        csr_plv_i,
    output dmem_req_t   dmem_req_o,
    input  logic        dmem_ready_i,
    input  logic        dmem_ack_i,
    output logic        ex_ready_o,
    output mem1_mem2_t  mem2_o
);

    logic       load_op;
    logic       store_op;
    logic       access_mem;
    logic       trans;
    logic       adem;
    word_t      paddr;
    excp_vec_t  excp;
    logic       mem_access_valid;
    logic       sc_fail;
    logic       need_req;
    logic       llbit;
    mem1_mem2_t mem2_d;

    assign load_op  = ex_i.valid && (ex_i.op inside {LD_B, LD_BU, LD_H, LD_HU, LD_W, LL});
    assign store_op = ex_i.valid && (ex_i.op inside {ST_B, ST_H, ST_W, SC});
    assign access_mem = load_op || store_op;
    assign trans = ex_i.trans_en;
    assign paddr = trans ? tlb_result_i.paddr : ex_i.vaddr;

    // ADEM takes priority over the TLB checks
    assign adem = access_mem && trans && (csr_plv_i == 2'd3) && ex_i.vaddr[31];

    always_comb begin
        excp = '0;
        excp[`LSU_EXCP_ADEM] = adem;
        if (access_mem && trans && !adem) begin
            excp[`LSU_EXCP_TLBR] = !tlb_result_i.found;
            excp[`LSU_EXCP_PIL]  = load_op && tlb_result_i.found && !tlb_result_i.v;
            excp[`LSU_EXCP_PIS]  = store_op && tlb_result_i.found && !tlb_result_i.v;
            excp[`LSU_EXCP_PPI]  = tlb_result_i.found && tlb_result_i.v
                                   && (csr_plv_i > tlb_result_i.plv);
            excp[`LSU_EXCP_PME]  = store_op && tlb_result_i.found && tlb_result_i.v
                                   && (csr_plv_i <= tlb_result_i.plv) && !tlb_result_i.d;
        end
    end

    assign mem_access_valid = access_mem && (excp == '0);

    // SC without a reservation completes without touching memory
    assign sc_fail  = (ex_i.op == SC) && !llbit;
    assign need_req = mem_access_valid && !sc_fail;
    assign ex_ready_o = !need_req || dmem_ack_i;

    always_comb begin
        dmem_req_o = '0;
        if (need_req && dmem_ready_i) begin
            dmem_req_o.ce   = 1'b1;
            dmem_req_o.we   = store_op;
            dmem_req_o.addr = paddr;
            case (ex_i.op)
                LD_B, LD_BU, ST_B: dmem_req_o.sel = byte_sel_t'(4'b0001) << paddr[1:0];
                LD_H, LD_HU, ST_H: dmem_req_o.sel = byte_sel_t'(4'b0011) << paddr[1:0];
                default:           dmem_req_o.sel = 4'b1111;
            endcase
            case (ex_i.op)
                ST_B:     dmem_req_o.data = word_t'(ex_i.sdata[7:0]) << {paddr[1:0], 3'b000};
                ST_H:     dmem_req_o.data = word_t'(ex_i.sdata[15:0]) << {paddr[1:0], 3'b000};
                ST_W, SC: dmem_req_o.data = ex_i.sdata;
                default:  dmem_req_o.data = '0;
            endcase
        end
    end

    // LL/SC reservation is updated when the record leaves
    always_ff @(posedge clk) begin
        if (rst) begin
            llbit <= 1'b0;
        end else if (ex_ready_o && mem_access_valid) begin
            if (ex_i.op == LL) begin
                llbit <= 1'b1;
            end else if (ex_i.op == SC) begin
                llbit <= 1'b0;
            end
        end
    end

    always_comb begin
        mem2_d.valid            = ex_i.valid;
        mem2_d.op               = ex_i.op;
        mem2_d.paddr_lo         = paddr[1:0];
        mem2_d.wreg             = ex_i.wreg;
        mem2_d.waddr            = ex_i.waddr;
        mem2_d.wdata            = ex_i.wdata;
        mem2_d.excp             = excp;
        mem2_d.mem_access_valid = mem_access_valid;
        // SC result is the reservation state at issue
        if (mem_access_valid && (ex_i.op == SC)) begin
            mem2_d.wreg  = 1'b1;
            mem2_d.wdata = word_t'(llbit);
        end
    end

    // Bubble while waiting for ack so nothing is written back twice
    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            mem2_o <= '0;
        end else begin
            mem2_o <= ex_ready_o ? mem2_d : '0;
        end
    end

    // Ack releases the held record in the next cycle
    a_req_then_advance: assert property (
        @(posedge clk) disable iff (rst) dmem_req_o.ce |=> ex_ready_o
    ) else $error("mem1_stage: no advance after request");

endmodule

// ==== hw/dtlb.sv ====
`timescale 1ns/10ps
`include "lsu_settings.svh"

module dtlb
    import lsu_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  word_t       vaddr_i,
    input  logic        we_i,
    input  logic [1:0]  widx_i,
    input  tlb_entry_t  entry_i,
    output tlb_result_t result_o
);

    tlb_entry_t                   entries [`LSU_TLB_ENTRIES];
    logic [`LSU_TLB_ENTRIES-1:0]  present;
    logic [`LSU_TLB_ENTRIES-1:0]  hit;
    vppn_t                        vppn;

    assign vppn = vaddr_i[31:12];

    // Entry contents, one slot per cycle
    always_ff @(posedge clk) begin
        if (we_i) begin
            entries[widx_i] <= entry_i;
        end
    end

    // Slot occupancy, empty after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            present <= '0;
        end else if (we_i) begin
            present[widx_i] <= 1'b1;
        end
    end

    always_comb begin
        for (int i = 0; i < `LSU_TLB_ENTRIES; i++) begin
            hit[i] = present[i] && (entries[i].vppn == vppn);
        end
    end

    // Walk downwards so the lowest matching slot wins
    always_comb begin
        result_o = '0;
        for (int i = `LSU_TLB_ENTRIES - 1; i >= 0; i--) begin
            if (hit[i]) begin
                result_o.found = 1'b1;
                result_o.paddr = {entries[i].ppn, vaddr_i[11:0]};
                result_o.v     = entries[i].v;
                result_o.d     = entries[i].d;
                result_o.plv   = entries[i].plv;
            end
        end
    end

    // Software must never map one page twice
    a_single_hit: assert property (
        @(posedge clk) disable iff (rst) $onehot0(hit)
    ) else $error("dtlb: several entries match vppn %h", vppn);

endmodule

// ==== hw/lsu_pkg.sv ====
`include "lsu_settings.svh"

package lsu_pkg;

    typedef logic [`LSU_XLEN-1:0]   word_t;
    typedef logic [19:0]            vppn_t;
    typedef logic [19:0]            ppn_t;
    typedef logic [4:0]             reg_addr_t;
    typedef logic [1:0]             plv_t;
    typedef logic [3:0]             byte_sel_t;
    typedef logic [`LSU_EXCP_W-1:0] excp_vec_t;

    typedef enum logic [3:0] {
        NONE,
        LD_B,
        LD_BU,
        LD_H,
        LD_HU,
        LD_W,
        ST_B,
        ST_H,
        ST_W,
        LL,
        SC
    } mem_op_e;

    // Record from the execute stage
    typedef struct packed {
        logic      valid;
        mem_op_e   op;
        word_t     vaddr;
        word_t     sdata;
        logic      wreg;
        reg_addr_t waddr;
        word_t     wdata;
        logic      trans_en;
    } ex_mem_t;

    typedef struct packed {
        vppn_t vppn;
        ppn_t  ppn;
        logic  v;
        logic  d;
        plv_t  plv;
    } tlb_entry_t;

    typedef struct packed {
        logic  found;
        word_t paddr;
        logic  v;
        logic  d;
        plv_t  plv;
    } tlb_result_t;

    typedef struct packed {
        logic      ce;
        logic      we;
        word_t     addr;
        byte_sel_t sel;
        word_t     data;
    } dmem_req_t;

    typedef struct packed {
        logic      valid;
        mem_op_e   op;
        logic [1:0] paddr_lo;
        logic      wreg;
        reg_addr_t waddr;
        word_t     wdata;
        excp_vec_t excp;
        logic      mem_access_valid;
    } mem1_mem2_t;

    typedef struct packed {
        logic      valid;
        logic      wreg;
        reg_addr_t waddr;
        word_t     wdata;
        excp_vec_t excp;
    } wb_t;

endpackage

// ==== hw/lsu_settings.svh ====
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// Datapath width, addresses and data alike
`define LSU_XLEN        32

`define LSU_TLB_ENTRIES 4

// Word-organised, indexed by paddr[9:2]
`define LSU_DMEM_WORDS  256

`define LSU_EXCP_W      6

// Bit positions in the exception vector
`define LSU_EXCP_ADEM   0
`define LSU_EXCP_TLBR   1
`define LSU_EXCP_PIL    2
`define LSU_EXCP_PIS    3
`define LSU_EXCP_PPI    4
`define LSU_EXCP_PME    5

`endif
